/* all.f */
rtl/cache_geom_pkg.sv
rtl/cache_bus_pkg.sv
rtl/cache_sram.sv
rtl/cache_controller.sv
rtl/l1_cache.sv
rtl/backing_memory.sv
rtl/mem_subsystem_top.sv
verif/l1_cache_chk.sv
verif/tb_mem_subsystem.sv

/* verif/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;

	localparam int MEM_LATENCY   = 4;
	localparam int NUM_DIRECTED  = 19;
	localparam int NUM_RANDOM    = 200;
	localparam int STALL_TIMEOUT = 100;
	localparam int MODEL_WORDS   = 1024;

	typedef struct packed {
		logic        we;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        expect_hit;
	} access_t;

	logic                    clk;
	logic                    rst_n_i;
	cache_bus_pkg::cpu_req_t cpu_req;
	cache_geom_pkg::word_t   rdata;
	logic                    stall;

	logic [31:0] model [MODEL_WORDS];
	logic [31:0] seed;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed table of we, address, write data and expected hit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	access_t directed [NUM_DIRECTED] = '{
		'{1'b0, 32'h0000_0040, 32'h0000_0000, 1'b0},
		'{1'b0, 32'h0000_0044, 32'h0000_0000, 1'b1},
		'{1'b1, 32'h0000_0048, 32'hdead_beef, 1'b1},
		'{1'b0, 32'h0000_0048, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h0000_004c, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h0000_0040, 32'h0000_0000, 1'b1},
		// Same index and a new tag send the dirty victim out
		'{1'b0, 32'h0000_0440, 32'h0000_0000, 1'b0},
		'{1'b0, 32'h0000_0048, 32'h0000_0000, 1'b0},
		'{1'b1, 32'h0000_0448, 32'h1234_5678, 1'b0},
		'{1'b0, 32'h0000_0048, 32'h0000_0000, 1'b0},
		'{1'b0, 32'h0000_0448, 32'h0000_0000, 1'b0},
		// Every word of one cold line
		'{1'b0, 32'h0000_0800, 32'h0000_0000, 1'b0},
		'{1'b0, 32'h0000_0804, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h0000_0808, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h0000_080c, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h0000_0810, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h0000_0814, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h0000_0818, 32'h0000_0000, 1'b1},
		'{1'b0, 32'h0000_081c, 32'h0000_0000, 1'b1}
	};

	mem_subsystem_top #(
		.MEM_LATENCY (MEM_LATENCY)
	) uut (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.cpu_req_i (cpu_req),
		.rdata_o   (rdata),
		.stall_o   (stall)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic report_failure(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	// One CPU access that returns the read word and the stall length
	task automatic run_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
			output logic [31:0] rd, output int cycles);
		@(posedge clk);
		#10;
		cpu_req.cs    = 1'b1;
		cpu_req.we    = we;
		cpu_req.addr  = addr;
		cpu_req.wdata = wdata;
		@(posedge clk);
		#10;
		cpu_req.cs = 1'b0;
		cycles     = 0;
		assert (stall === 1'b1) else report_failure("cache did not stall after a request");
		while (stall) begin
			cycles++;
			if (cycles > STALL_TIMEOUT) begin
				report_failure("cache never finished the access");
			end
			@(posedge clk);
			#10;
		end
		rd = rdata;
		assert (uut.u_cache.u_chk.fail_count == 0)
		else report_failure("a protocol assertion on the cache fired");
	endtask

	task automatic check_access(input access_t acc, input bit check_hit);
		logic [31:0] rd;
		logic [31:0] exp;
		int          cycles;
		int          widx;
		widx = acc.addr[11:2];
		exp  = model[widx];
		run_access(acc.we, acc.addr, acc.wdata, rd, cycles);
		if (acc.we) begin
			model[widx] = acc.wdata;
		end else begin
			assert (rd === exp) else report_mismatch($sformatf(
				"read of %08h returned %08h, expected %08h", acc.addr, rd, exp));
		end
		if (check_hit) begin
			assert ((cycles == 1) == acc.expect_hit) else report_mismatch($sformatf(
				"access to %08h stalled %0d cycles, expected a %s", acc.addr, cycles,
				acc.expect_hit ? "hit" : "miss"));
		end
	endtask

	initial begin
		access_t acc;
		cpu_req = '0;
		rst_n_i = 1'b0;
		seed    = 32'h9971_c4cd;
		for (int i = 0; i < MODEL_WORDS; i++) begin
			model[i] = ~(32'(i * 4));
		end
		repeat (5) @(posedge clk);
		#10;
		rst_n_i = 1'b1;
		assert (stall === 1'b0) else report_mismatch("stall_o is not low after reset");
		assert (uut.u_cache.mem_req_o.strobe === 1'b0)
		else report_mismatch("memory strobe is not low after reset");

		for (int i = 0; i < NUM_DIRECTED; i++) begin
			check_access(directed[i], 1'b1);
		end

		// Random mix inside the low 4 KB
		for (int i = 0; i < NUM_RANDOM; i++) begin
			seed           = xorshift32(seed);
			acc.we         = seed[31];
			acc.addr       = {20'h0, seed[11:2], 2'b00};
			seed           = xorshift32(seed);
			acc.wdata      = seed;
			acc.expect_hit = 1'b0;
			check_access(acc, 1'b0);
		end

		if (uut.u_cache.u_chk.fail_count == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1, "Errors were found");
		end
	end

endmodule

/* verif/l1_cache_chk.sv */
`timescale 1ns/1ps

module l1_cache_chk (
	input logic clk,
	input logic rst_n_i,
	input logic stall_i,
	input logic mem_strobe_i,
	input logic mem_ack_i
);

	int   fail_count = 0;
	logic pending_q;

	// Memory request outstanding
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pending_q <= 1'b0;
		end else if (mem_strobe_i) begin
			pending_q <= 1'b1;
		end else if (mem_ack_i) begin
			pending_q <= 1'b0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory port protocol
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	strobe_in_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		mem_strobe_i |-> stall_i)
	else begin
		fail_count++;
		$error("memory strobe seen while the cache is not stalled");
	end

	ack_after_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
		mem_ack_i |-> pending_q)
	else begin
		fail_count++;
		$error("memory ack without an outstanding strobe");
	end

	strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
		mem_strobe_i |=> !mem_strobe_i)
	else begin
		fail_count++;
		$error("memory strobe held for more than one cycle");
	end

	// CPU side
	stall_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$isunknown(stall_i))
	else begin
		fail_count++;
		$error("stall_o is unknown");
	end

endmodule

bind l1_cache l1_cache_chk u_chk (
	.clk          (clk),
	.rst_n_i      (rst_n_i),
	.stall_i      (stall_o),
	.mem_strobe_i (mem_req_o.strobe),
	.mem_ack_i    (mem_rsp_i.ack)
);

/* rtl/mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top #(
	parameter int MEM_LATENCY = 4
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  cache_bus_pkg::cpu_req_t cpu_req_i,
	output cache_geom_pkg::word_t   rdata_o,
	output logic                    stall_o
);

	cache_bus_pkg::mem_req_t mem_req;
	cache_bus_pkg::mem_rsp_t mem_rsp;

	l1_cache u_cache (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.cpu_req_i (cpu_req_i),
		.rdata_o   (rdata_o),
		.stall_o   (stall_o),
		.mem_req_o (mem_req),
		.mem_rsp_i (mem_rsp)
	);

	// 128 lines cover the low 4 KB
	backing_memory #(
		.MEM_LATENCY (MEM_LATENCY),
		.MEM_LINES   (128)
	) u_mem (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.mem_req_i (mem_req),
		.mem_rsp_o (mem_rsp)
	);

endmodule

/* rtl/backing_memory.sv */
`timescale 1ns/1ps

module backing_memory #(
	parameter int MEM_LATENCY = 4,
	parameter int MEM_LINES   = 128
) (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  cache_bus_pkg::mem_req_t mem_req_i,
	output cache_bus_pkg::mem_rsp_t mem_rsp_o
);

	localparam int LINE_IDX_W = $clog2(MEM_LINES);
	localparam int CNT_W      = $clog2(MEM_LATENCY + 1);

	cache_geom_pkg::line_t   mem [MEM_LINES];
	cache_geom_pkg::line_t   rd_line_q;
	logic [CNT_W-1:0]        cnt_q;
	logic [LINE_IDX_W-1:0]   line_idx;

	assign line_idx = mem_req_i.line_addr[LINE_IDX_W-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Each word comes up as the inverse of its own byte address
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int l = 0; l < MEM_LINES; l++) begin
				for (int w = 0; w < cache_geom_pkg::WORDS_PER_LINE; w++) begin
					mem[l][w] <= ~(32'((l * cache_geom_pkg::WORDS_PER_LINE + w) * 4));
				end
			end
		end else if (mem_req_i.strobe && mem_req_i.we) begin
			mem[line_idx] <= mem_req_i.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_req_i.strobe && !mem_req_i.we) begin
			rd_line_q <= mem[line_idx];
		end
	end

	// Latency counter, a new strobe reloads it
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
		end else if (mem_req_i.strobe) begin
			cnt_q <= CNT_W'(MEM_LATENCY);
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	always_comb begin
		mem_rsp_o.ack   = (cnt_q == CNT_W'(1));
		mem_rsp_o.rdata = rd_line_q;
	end

endmodule

/* rtl/l1_cache.sv */
`timescale 1ns/1ps

module l1_cache (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  cache_bus_pkg::cpu_req_t cpu_req_i,
	output cache_geom_pkg::word_t   rdata_o,
	output logic                    stall_o,
	output cache_bus_pkg::mem_req_t mem_req_o,
	input  cache_bus_pkg::mem_rsp_t mem_rsp_i
);

	cache_bus_pkg::cpu_req_t            req_q;
	cache_geom_pkg::cpu_addr_t          addr_q;
	logic [cache_geom_pkg::INDEX_W-1:0] array_idx;
	logic                               array_cs;

	cache_geom_pkg::tag_entry_t tag_rd;
	cache_geom_pkg::tag_entry_t tag_wr;
	cache_geom_pkg::line_t      line_rd;
	cache_geom_pkg::line_t      line_wr;
	cache_geom_pkg::line_t      merge_line;
	cache_geom_pkg::line_t      fill_q;

	logic hit;
	logic dirty;
	logic tag_we;
	logic data_we;
	logic fill_sel;
	logic wb_sel;
	logic mem_strobe;
	logic mem_we;
	logic lookup_hit;
	logic tag_wr_en;
	logic data_wr_en;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request capture
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (cpu_req_i.cs && !stall_o) begin
			req_q <= cpu_req_i;
		end
	end

	assign addr_q = req_q.addr;

	// Idle cycles look up the incoming address so the lookup cycle has data
	assign array_idx = stall_o ? addr_q.index : cpu_req_i.addr.index;
	assign array_cs  = stall_o | cpu_req_i.cs;

	// Hit compare
	assign hit   = tag_rd.valid && (tag_rd.tag == addr_q.tag);
	assign dirty = tag_rd.valid && tag_rd.dirty;

	always_comb begin
		merge_line               = line_rd;
		merge_line[addr_q.word]  = req_q.wdata;
	end

	// Lookup hit is the only non-fill cycle with a write enable
	assign lookup_hit = data_we & ~fill_sel;
	assign tag_wr_en  = tag_we & (fill_sel | req_q.we);
	assign data_wr_en = data_we & (fill_sel | req_q.we);

	assign tag_wr  = '{valid: 1'b1, dirty: ~fill_sel, tag: addr_q.tag};
	assign line_wr = fill_sel ? fill_q : merge_line;

	always_ff @(posedge clk) begin
		if (mem_rsp_i.ack) begin
			fill_q <= mem_rsp_i.rdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdata_o <= '0;
		end else if (lookup_hit && !req_q.we) begin
			rdata_o <= line_rd[addr_q.word];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		mem_req_o.strobe    = mem_strobe;
		mem_req_o.we        = mem_we;
		// Victim address on write-back, else the missed line
		mem_req_o.line_addr = wb_sel ? {tag_rd.tag, addr_q.index}
		                             : {addr_q.tag, addr_q.index};
		mem_req_o.wdata     = line_rd;
	end

	cache_controller u_ctrl (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.req_cs_i     (cpu_req_i.cs),
		.hit_i        (hit),
		.dirty_i      (dirty),
		.mem_ack_i    (mem_rsp_i.ack),
		.stall_o      (stall_o),
		.tag_we_o     (tag_we),
		.data_we_o    (data_we),
		.fill_sel_o   (fill_sel),
		.mem_strobe_o (mem_strobe),
		.mem_we_o     (mem_we),
		.wb_sel_o     (wb_sel)
	);

	cache_sram #(
		.payload_t    (cache_geom_pkg::tag_entry_t),
		.DEPTH        (cache_geom_pkg::LINES),
		.CLEAR_ON_RST (1'b1)
	) u_tag_ram (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.cs_i    (array_cs),
		.we_i    (tag_wr_en),
		.addr_i  (array_idx),
		.wdata_i (tag_wr),
		.rdata_o (tag_rd)
	);

	cache_sram #(
		.payload_t    (cache_geom_pkg::line_t),
		.DEPTH        (cache_geom_pkg::LINES),
		.CLEAR_ON_RST (1'b0)
	) u_line_ram (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.cs_i    (array_cs),
		.we_i    (data_wr_en),
		.addr_i  (array_idx),
		.wdata_i (line_wr),
		.rdata_o (line_rd)
	);

endmodule

/* rtl/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller (
	input  logic clk,
	input  logic rst_n_i,
	input  logic req_cs_i,
	input  logic hit_i,
	input  logic dirty_i,
	input  logic mem_ack_i,
	output logic stall_o,
	output logic tag_we_o,
	output logic data_we_o,
	output logic fill_sel_o,
	output logic mem_strobe_o,
	output logic mem_we_o,
	output logic wb_sel_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WRITEBACK,
		ST_REFILL_WAIT,
		ST_FILL
	} state_t;

	state_t state_q;
	state_t state_d;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state and outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		state_d      = state_q;
		tag_we_o     = 1'b0;
		data_we_o    = 1'b0;
		fill_sel_o   = 1'b0;
		mem_strobe_o = 1'b0;
		mem_we_o     = 1'b0;
		wb_sel_o     = 1'b0;

		case (state_q)
			ST_IDLE: begin
				if (req_cs_i) begin
					state_d = ST_LOOKUP;
				end
			end

			ST_LOOKUP: begin
				if (hit_i) begin
					// Update allowed, datapath keeps it only for writes
					tag_we_o  = 1'b1;
					data_we_o = 1'b1;
					state_d   = ST_IDLE;
				end else if (dirty_i) begin
					// Victim goes out first
					mem_strobe_o = 1'b1;
					mem_we_o     = 1'b1;
					wb_sel_o     = 1'b1;
					state_d      = ST_WRITEBACK;
				end else begin
					mem_strobe_o = 1'b1;
					state_d      = ST_REFILL_WAIT;
				end
			end

			ST_WRITEBACK: begin
				// Refill request leaves in the same cycle as the write ack
				if (mem_ack_i) begin
					mem_strobe_o = 1'b1;
					state_d      = ST_REFILL_WAIT;
				end
			end

			ST_REFILL_WAIT: begin
				if (mem_ack_i) begin
					state_d = ST_FILL;
				end
			end

			ST_FILL: begin
				tag_we_o   = 1'b1;
				data_we_o  = 1'b1;
				fill_sel_o = 1'b1;
				state_d    = ST_LOOKUP;
			end

			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	assign stall_o = (state_q != ST_IDLE);

endmodule

/* rtl/cache_sram.sv */
`timescale 1ns/1ps

module cache_sram #(
	parameter type payload_t    = logic [31:0],
	parameter int  DEPTH        = 32,
	parameter bit  CLEAR_ON_RST = 1'b0
) (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  logic                     cs_i,
	input  logic                     we_i,
	input  logic [$clog2(DEPTH)-1:0] addr_i,
	input  payload_t                 wdata_i,
	output payload_t                 rdata_o
);

	payload_t mem [DEPTH];

	generate
		if (CLEAR_ON_RST) begin : g_clear
			// Tag array, every entry invalid after reset
			always_ff @(posedge clk or negedge rst_n_i) begin
				if (!rst_n_i) begin
					for (int i = 0; i < DEPTH; i++) begin
						mem[i] <= '0;
					end
				end else if (cs_i && we_i) begin
					mem[addr_i] <= wdata_i;
				end
			end
		end else begin : g_plain
			always_ff @(posedge clk) begin
				if (cs_i && we_i) begin
					mem[addr_i] <= wdata_i;
				end
			end
		end
	endgenerate

	// Registered read, write data passes straight through
	always_ff @(posedge clk) begin
		if (cs_i) begin
			rdata_o <= we_i ? wdata_i : mem[addr_i];
		end
	end

endmodule

/* rtl/cache_bus_pkg.sv */
package cache_bus_pkg;

	// Upper address bits that name a whole line
	localparam int LINE_ADDR_W = cache_geom_pkg::TAG_W + cache_geom_pkg::INDEX_W;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CPU port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic                      cs;
		logic                      we;
		cache_geom_pkg::cpu_addr_t addr;
		cache_geom_pkg::word_t     wdata;
	} cpu_req_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory port, whole lines only
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic                   strobe;
		logic                   we;
		logic [LINE_ADDR_W-1:0] line_addr;
		cache_geom_pkg::line_t  wdata;
	} mem_req_t;

	typedef struct packed {
		logic                  ack;
		cache_geom_pkg::line_t rdata;
	} mem_rsp_t;

endpackage

/* rtl/cache_geom_pkg.sv */
package cache_geom_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Cache geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int TAG_W          = 22;
	localparam int INDEX_W        = 5;
	localparam int OFFSET_W       = 5;
	localparam int WORD_SEL_W     = OFFSET_W - 2;
	localparam int WORD_W         = 32;
	localparam int WORDS_PER_LINE = 8;
	localparam int LINES          = 32;

	typedef logic [WORD_W-1:0] word_t;

	// Byte address as the cache sees it
	typedef struct packed {
		logic [TAG_W-1:0]      tag;
		logic [INDEX_W-1:0]    index;
		logic [WORD_SEL_W-1:0] word;
		logic [1:0]            byte_off;
	} cpu_addr_t;

	// One entry of the tag array, 24 bits
	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	// Word 0 sits in the low bits
	typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

endpackage
